/* design/cache_params.svh */
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// Request side widths
`define CACHE_ADDR_WIDTH 32
`define CACHE_WORD_WIDTH 32

// Line geometry, four words of 32 bits
`define CACHE_LINE_BITS 128
`define CACHE_NUM_LINES 4
`define CACHE_WORDS_PER_LINE 4

// Byte offset inside a line covers word select and byte select
`define CACHE_OFFSET_WIDTH 4

// Everything above the offset is tag, the cache is fully associative
`define CACHE_TAG_WIDTH (`CACHE_ADDR_WIDTH - `CACHE_OFFSET_WIDTH)

// Backing store depth in whole lines
`define CACHE_MEM_LINES 64

`endif

/* design/cache_pkg.sv */
`include "cache_params.svh"

package cache_pkg;

    // Request address and data word
    typedef logic [`CACHE_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`CACHE_WORD_WIDTH-1:0] word_t;

    // One full cache line as moved to and from memory
    typedef logic [`CACHE_LINE_BITS-1:0] line_t;
    typedef logic [`CACHE_TAG_WIDTH-1:0] tag_t;

    // Fields of the line offset
    typedef logic [$clog2(`CACHE_WORDS_PER_LINE)-1:0] word_sel_t;
    typedef logic [$clog2(`CACHE_WORD_WIDTH/8)-1:0] byte_sel_t;

    // Line number and its LRU age
    typedef logic [$clog2(`CACHE_NUM_LINES)-1:0] way_t;
    typedef logic [1:0] lru_age_t;

    // Per-line flags and the stored tags side by side
    typedef logic [`CACHE_NUM_LINES-1:0] valid_vec_t;
    typedef tag_t [`CACHE_NUM_LINES-1:0] tag_array_t;

    // Controller sequence
    typedef enum logic [2:0] {
        idle,
        lookup,
        write_back,
        refill_req,
        refill_wait,
        complete
    } cache_state_t;

endpackage

/* design/mem_line_if.sv */
interface mem_line_if;
    import cache_pkg::*;

    // Strobes, never both high in one cycle
    logic read_enable;
    logic write_enable;

    // Line number in memory, low bits of the tag select the entry
    tag_t line_address;

    // Whole line payloads
    line_t write_data;
    line_t read_data;

    // Cache side drives requests and takes the read line
    modport controller (
        output read_enable,
        output write_enable,
        output line_address,
        output write_data,
        input  read_data
    );

    // Memory side answers with the registered read line
    modport memory (
        input  read_enable,
        input  write_enable,
        input  line_address,
        input  write_data,
        output read_data
    );

endinterface

/* design/tag_match.sv */
`include "cache_params.svh"

module tag_match (
    input  cache_pkg::tag_t       lookup_tag,
    input  cache_pkg::tag_array_t tags,
    input  cache_pkg::valid_vec_t valid,
    output logic                  way_hit,
    output cache_pkg::way_t       hit_way
);
    import cache_pkg::*;

    // One compare result per line
    valid_vec_t match;

    // Tag comparators, an invalid line never matches
    always_comb begin
        for (int i = 0; i < `CACHE_NUM_LINES; i++) begin
            match[i] = valid[i] && (tags[i] == lookup_tag);
        end
    end

    // Any match means a hit
    assign way_hit = |match;

    // Priority encoder
    // Scan from the top so the lowest matching index is the last written
    always_comb begin
        hit_way = '0;
        for (int i = `CACHE_NUM_LINES - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_way = way_t'(i);
            end
        end
    end

endmodule

/* design/lru_tracker.sv */
`include "cache_params.svh"

module lru_tracker (
    input  logic            clk,
    input  logic            reset,
    input  logic            touch,
    input  cache_pkg::way_t touch_way,
    output cache_pkg::way_t victim_way
);
    import cache_pkg::*;

    // Age per line, 3 is most recent and 0 is next to go
    lru_age_t ages [`CACHE_NUM_LINES];

    // Age of the line being touched, used as the threshold
    lru_age_t touched_age;

    assign touched_age = ages[touch_way];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            // Start as a permutation so line 0 goes first
            for (int i = 0; i < `CACHE_NUM_LINES; i++) begin
                ages[i] <= lru_age_t'(i);
            end
        end else if (touch) begin
            for (int i = 0; i < `CACHE_NUM_LINES; i++) begin
                if (way_t'(i) == touch_way) begin
                    // Touched line becomes most recent
                    ages[i] <= lru_age_t'(`CACHE_NUM_LINES - 1);
                end else if (ages[i] > touched_age) begin
                    // Younger lines slide down one step
                    ages[i] <= ages[i] - 1'b1;
                end
            end
        end
    end

    // Victim is whichever line holds age zero
    always_comb begin
        victim_way = '0;
        for (int i = 0; i < `CACHE_NUM_LINES; i++) begin
            if (ages[i] == '0) begin
                victim_way = way_t'(i);
            end
        end
    end

endmodule

/* design/cache_controller.sv */
`include "cache_params.svh"

module cache_controller (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  access,
    input  logic                  op,
    input  logic                  byte_op,
    input  cache_pkg::addr_t      address,
    input  cache_pkg::word_t      data_in,
    output cache_pkg::word_t      data_out,
    output logic                  hit,
    output logic                  miss,
    output logic                  busy,
    output cache_pkg::tag_t       lookup_tag,
    output cache_pkg::tag_array_t tags,
    output cache_pkg::valid_vec_t valid,
    input  logic                  way_hit,
    input  cache_pkg::way_t       hit_way,
    output logic                  touch,
    output cache_pkg::way_t       touch_way,
    input  cache_pkg::way_t       victim_way,
    mem_line_if.controller        mem
);
    import cache_pkg::*;

    cache_state_t state;

    // Request captured on the access cycle
    logic  req_op;
    logic  req_byte_op;
    addr_t req_addr;
    word_t req_data;

    // Address fields of the held request
    word_sel_t req_word;
    byte_sel_t req_byte;

    // Line storage
    tag_array_t tag_array;
    line_t      data_array [`CACHE_NUM_LINES];
    valid_vec_t dirty;

    // Line chosen for replacement on a miss
    way_t victim;

    // Store a word or a single byte into a line
    function automatic line_t merge_line(line_t line, word_sel_t w, byte_sel_t b,
                                         logic byte_mode, word_t wdata);
        line_t result;
        result = line;
        if (byte_mode) begin
            result[w*`CACHE_WORD_WIDTH + b*8 +: 8] = wdata[7:0];
        end else begin
            result[w*`CACHE_WORD_WIDTH +: `CACHE_WORD_WIDTH] = wdata;
        end
        return result;
    endfunction

    // Pick a word out of a line, bytes come back zero-extended
    function automatic word_t read_word(line_t line, word_sel_t w, byte_sel_t b,
                                        logic byte_mode);
        word_t word;
        word = line[w*`CACHE_WORD_WIDTH +: `CACHE_WORD_WIDTH];
        if (byte_mode) begin
            return {{(`CACHE_WORD_WIDTH-8){1'b0}}, word[b*8 +: 8]};
        end
        return word;
    endfunction

    assign lookup_tag = req_addr[`CACHE_ADDR_WIDTH-1:`CACHE_OFFSET_WIDTH];
    assign req_word   = req_addr[`CACHE_OFFSET_WIDTH-1:2];
    assign req_byte   = req_addr[1:0];
    assign tags       = tag_array;

    // Busy from the access edge until the completion cycle ends
    assign busy = (state != idle);

    // LRU update on a hit in lookup or on the install of a refilled line
    assign touch     = ((state == lookup) && way_hit) || (state == refill_wait);
    assign touch_way = (state == refill_wait) ? victim : hit_way;

    // Memory strobes decode straight from the state
    assign mem.write_enable = (state == write_back);
    assign mem.read_enable  = (state == refill_req);
    // Old tag for the write-back, requested tag for the refill
    assign mem.line_address = (state == write_back) ? tag_array[victim] : lookup_tag;
    assign mem.write_data   = data_array[victim];

    // Payload storage, request, tags and line data
    always_ff @(posedge clk) begin
        if ((state == idle) && access) begin
            req_op      <= op;
            req_byte_op <= byte_op;
            req_addr    <= address;
            req_data    <= data_in;
        end
        // Write hit merges into the hit line
        if ((state == lookup) && way_hit && !req_op) begin
            data_array[hit_way] <= merge_line(data_array[hit_way], req_word, req_byte,
                                              req_byte_op, req_data);
        end
        // Install refilled line, merging the write if there is one
        if (state == refill_wait) begin
            tag_array[victim] <= lookup_tag;
            if (req_op) begin
                data_array[victim] <= mem.read_data;
            end else begin
                data_array[victim] <= merge_line(mem.read_data, req_word, req_byte,
                                                 req_byte_op, req_data);
            end
        end
    end

    // FSM and per-line flags
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= idle;
            valid    <= '0;
            dirty    <= '0;
            victim   <= '0;
            hit      <= 1'b0;
            miss     <= 1'b0;
            data_out <= '0;
        end else begin
            // Hit and miss are single-cycle pulses
            hit  <= 1'b0;
            miss <= 1'b0;
            case (state)
                idle: begin
                    if (access) begin
                        state <= lookup;
                    end
                end
                lookup: begin
                    if (way_hit) begin
                        hit   <= 1'b1;
                        state <= complete;
                        if (req_op) begin
                            data_out <= read_word(data_array[hit_way], req_word, req_byte,
                                                  req_byte_op);
                        end else begin
                            dirty[hit_way] <= 1'b1;
                        end
                    end else begin
                        victim <= victim_way;
                        // Clean or empty victims skip the write-back
                        if (valid[victim_way] && dirty[victim_way]) begin
                            state <= write_back;
                        end else begin
                            state <= refill_req;
                        end
                    end
                end
                write_back: state <= refill_req;
                // Memory answers one cycle after the read strobe
                refill_req: state <= refill_wait;
                refill_wait: begin
                    valid[victim] <= 1'b1;
                    dirty[victim] <= !req_op;
                    miss          <= 1'b1;
                    state         <= complete;
                    if (req_op) begin
                        data_out <= read_word(mem.read_data, req_word, req_byte, req_byte_op);
                    end
                end
                complete: state <= idle;
                default: state <= idle;
            endcase
        end
    end

endmodule

/* design/line_memory.sv */
`include "cache_params.svh"

module line_memory (
    input  logic     clk,
    input  logic     reset,
    mem_line_if.memory mem
);
    import cache_pkg::*;

    // Entry select is taken from the low tag bits
    localparam int index_width = $clog2(`CACHE_MEM_LINES);

    line_t mem_array [`CACHE_MEM_LINES];

    logic [index_width-1:0] index;

    assign index = mem.line_address[index_width-1:0];

    // Whole-line writes and registered reads
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            // Memory starts out all zero
            for (int i = 0; i < `CACHE_MEM_LINES; i++) begin
                mem_array[i] <= '0;
            end
            mem.read_data <= '0;
        end else begin
            if (mem.write_enable) begin
                mem_array[index] <= mem.write_data;
            end
            // Read line appears on the next edge and holds until the next read
            if (mem.read_enable) begin
                mem.read_data <= mem_array[index];
            end
        end
    end

endmodule

/* design/cache_top.sv */
module cache_top (
    input  logic             clk,
    input  logic             reset,
    input  logic             access,
    input  logic             op,
    input  logic             byte_op,
    input  cache_pkg::addr_t address,
    input  cache_pkg::word_t data_in,
    output cache_pkg::word_t data_out,
    output logic             hit,
    output logic             miss,
    output logic             busy
);
    import cache_pkg::*;

    // Lookup path between controller and tag match
    tag_t       lookup_tag;
    tag_array_t tags;
    valid_vec_t valid;
    logic       way_hit;
    way_t       hit_way;

    // LRU path
    logic touch;
    way_t touch_way;
    way_t victim_way;

    // Line traffic to the backing memory
    mem_line_if mem_bus ();

    cache_controller u_controller (
        .clk        (clk),
        .reset      (reset),
        .access     (access),
        .op         (op),
        .byte_op    (byte_op),
        .address    (address),
        .data_in    (data_in),
        .data_out   (data_out),
        .hit        (hit),
        .miss       (miss),
        .busy       (busy),
        .lookup_tag (lookup_tag),
        .tags       (tags),
        .valid      (valid),
        .way_hit    (way_hit),
        .hit_way    (hit_way),
        .touch      (touch),
        .touch_way  (touch_way),
        .victim_way (victim_way),
        .mem        (mem_bus.controller)
    );

    tag_match u_tag_match (
        .lookup_tag (lookup_tag),
        .tags       (tags),
        .valid      (valid),
        .way_hit    (way_hit),
        .hit_way    (hit_way)
    );

    lru_tracker u_lru (
        .clk        (clk),
        .reset      (reset),
        .touch      (touch),
        .touch_way  (touch_way),
        .victim_way (victim_way)
    );

    line_memory u_memory (
        .clk   (clk),
        .reset (reset),
        .mem   (mem_bus.memory)
    );

endmodule

/* bench/cache_properties.sv */
module cache_properties (
    input logic clk,
    input logic reset,
    input logic access,
    input logic busy,
    input logic hit,
    input logic miss,
    input logic read_enable,
    input logic write_enable
);
    timeunit 1ns;
    timeprecision 1ps;

    // Failed assertions, read by the testbench summary
    int unsigned failures = 0;

    // Completion pulses are exclusive
    hit_miss_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(hit && miss))
        else begin
            failures++;
            $error("hit and miss are high in the same cycle");
        end

    // Requester only strobes while the cache is free
    access_while_idle: assert property (@(posedge clk) disable iff (reset)
        access |-> !busy)
        else begin
            failures++;
            $error("access strobe arrived while busy was high");
        end

    // Memory strobes never overlap
    strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(read_enable && write_enable))
        else begin
            failures++;
            $error("memory read and write strobes are high together");
        end

    // Worst case is a dirty miss
    access_answered: assert property (@(posedge clk) disable iff (reset)
        access |-> ##[1:6] (hit || miss))
        else begin
            failures++;
            $error("access got no hit or miss within 6 cycles");
        end

    // Cache frees up right after the completion pulse
    idle_after_done: assert property (@(posedge clk) disable iff (reset)
        (hit || miss) |=> !busy)
        else begin
            failures++;
            $error("busy still high in the cycle after hit or miss");
        end

endmodule

bind cache_top cache_properties u_properties (
    .clk          (clk),
    .reset        (reset),
    .access       (access),
    .busy         (busy),
    .hit          (hit),
    .miss         (miss),
    .read_enable  (mem_bus.read_enable),
    .write_enable (mem_bus.write_enable)
);

/* bench/cache_tb.sv */
`include "cache_params.svh"

module cache_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cache_pkg::*;

    // 700 requests of at most 8 cycles each, plus reset and slack
    localparam int watchdog_ns    = 700 * 8 * 40 + 10000;
    localparam int response_limit = 10;
    localparam int space_bytes    = 8 * 16;

    logic  clk;
    logic  reset;
    logic  access;
    logic  op;
    logic  byte_op;
    addr_t address;
    word_t data_in;
    word_t data_out;
    logic  hit;
    logic  miss;
    logic  busy;

    // Run bookkeeping
    int          errors;
    int          tests_run;
    int          tests_failed;
    logic [31:0] lfsr_state;

    // Byte image of tags 0 to 7
    logic [7:0] image [space_bytes];

    // Four tag slots with true LRU ages
    logic     model_valid [4];
    logic     model_dirty [4];
    tag_t     model_tag [4];
    lru_age_t model_age [4];

    cache_top u_dut (
        .clk      (clk),
        .reset    (reset),
        .access   (access),
        .op       (op),
        .byte_op  (byte_op),
        .address  (address),
        .data_in  (data_in),
        .data_out (data_out),
        .hit      (hit),
        .miss     (miss),
        .busy     (busy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] random_bits(int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("MISMATCH time %0d ns signal %s expected %h got %h",
                 $time, name, expected, actual);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("ERROR time %0d ns: %s", $time, what);
    endtask

    task automatic model_reset();
        for (int i = 0; i < space_bytes; i++) begin
            image[i] = 8'h00;
        end
        // Ages start at the line index so slot 0 goes first
        for (int i = 0; i < 4; i++) begin
            model_valid[i] = 1'b0;
            model_dirty[i] = 1'b0;
            model_tag[i]   = '0;
            model_age[i]   = lru_age_t'(i);
        end
    endtask

    // Lowest matching slot wins
    task automatic model_find(input tag_t tag, output logic found, output way_t way);
        found = 1'b0;
        way   = '0;
        for (int i = 3; i >= 0; i--) begin
            if (model_valid[i] && model_tag[i] == tag) begin
                found = 1'b1;
                way   = way_t'(i);
            end
        end
    endtask

    function automatic way_t model_victim();
        way_t way;
        way = '0;
        for (int i = 0; i < 4; i++) begin
            if (model_age[i] == 2'd0) begin
                way = way_t'(i);
            end
        end
        return way;
    endfunction

    // Touched slot becomes newest, younger ones slide down
    task automatic model_touch(input way_t way);
        lru_age_t threshold;
        threshold = model_age[way];
        for (int i = 0; i < 4; i++) begin
            if (way_t'(i) == way) begin
                model_age[i] = 2'd3;
            end else if (model_age[i] > threshold) begin
                model_age[i] = model_age[i] - 2'd1;
            end
        end
    endtask

    // Count falling edges after the access edge until hit or miss
    // Busy stays high through the request, completion cycle included
    task automatic wait_response(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (busy !== 1'b1) begin
                report_mismatch("busy", 1'b1, busy);
            end
        end while (!(hit || miss) && cycles < response_limit);
        if (!(hit || miss)) begin
            report_failure($sformatf("no hit or miss within %0d cycles of an access",
                                     response_limit));
        end
    endtask

    // One access, checked against the model, then the model is updated
    task automatic do_request(input logic rd, input logic bytes, input addr_t addr,
                              input word_t wdata, output logic got_hit,
                              output word_t got_data);
        tag_t  tag;
        logic  exp_hit;
        way_t  way;
        int    exp_cycles;
        int    cycles;
        int    base;
        word_t exp_data;
        tag  = addr[`CACHE_ADDR_WIDTH-1:`CACHE_OFFSET_WIDTH];
        base = {addr[6:2], 2'b00};
        model_find(tag, exp_hit, way);
        if (exp_hit) begin
            exp_cycles = 2;
        end else begin
            way = model_victim();
            // Dirty victim costs one write-back cycle
            exp_cycles = (model_valid[way] && model_dirty[way]) ? 5 : 4;
        end
        if (bytes) begin
            exp_data = {24'h0, image[addr[6:0]]};
        end else begin
            exp_data = {image[base+3], image[base+2], image[base+1], image[base]};
        end
        @(posedge clk);
        access  <= 1'b1;
        op      <= rd;
        byte_op <= bytes;
        address <= addr;
        data_in <= wdata;
        @(posedge clk);
        access <= 1'b0;
        wait_response(cycles);
        if (hit !== exp_hit) begin
            report_mismatch("hit", exp_hit, hit);
        end
        if (miss !== !exp_hit) begin
            report_mismatch("miss", !exp_hit, miss);
        end
        if (cycles != exp_cycles) begin
            report_mismatch("latency", exp_cycles, cycles);
        end
        if (rd && data_out !== exp_data) begin
            report_mismatch("data_out", exp_data, data_out);
        end
        // Miss installs a clean line in the victim slot
        if (!exp_hit) begin
            model_valid[way] = 1'b1;
            model_dirty[way] = 1'b0;
            model_tag[way]   = tag;
        end
        if (!rd) begin
            model_dirty[way] = 1'b1;
            if (bytes) begin
                image[addr[6:0]] = wdata[7:0];
            end else begin
                for (int k = 0; k < 4; k++) begin
                    image[base+k] = wdata[k*8 +: 8];
                end
            end
        end
        model_touch(way);
        got_hit  = hit;
        got_data = data_out;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAILED with %0d errors", tests_run, name,
                     errors - errors_before);
        end
    endtask

    task automatic test_reset();
        int    start;
        logic  h;
        word_t d;
        start = errors;
        @(negedge clk);
        if (hit !== 1'b0) report_mismatch("hit", 0, hit);
        if (miss !== 1'b0) report_mismatch("miss", 0, miss);
        if (busy !== 1'b0) report_mismatch("busy", 0, busy);
        do_request(1'b1, 1'b0, 32'h0000_0048, '0, h, d);
        if (h) report_failure("first read after reset hit an empty cache");
        if (d !== 32'h0) report_mismatch("data_out", 32'h0, d);
        finish_test("reset and first read", start);
    endtask

    task automatic test_word();
        int    start;
        logic  h;
        word_t d;
        start = errors;
        do_request(1'b0, 1'b0, 32'h0000_0014, 32'h1234_abcd, h, d);
        do_request(1'b1, 1'b0, 32'h0000_0014, '0, h, d);
        if (!h) report_failure("word read after a write to the same address missed");
        if (d !== 32'h1234_abcd) report_mismatch("data_out", 32'h1234_abcd, d);
        finish_test("word write then read", start);
    endtask

    task automatic test_bytes();
        int    start;
        logic  h;
        word_t d;
        start = errors;
        // One distinct byte per offset of word 2 in tag 2
        for (int b = 0; b < 4; b++) begin
            do_request(1'b0, 1'b1, 32'h28 + b, word_t'((b + 1) * 8'h11), h, d);
        end
        for (int b = 0; b < 4; b++) begin
            do_request(1'b1, 1'b1, 32'h28 + b, '0, h, d);
            if (d !== word_t'((b + 1) * 8'h11)) begin
                report_mismatch("data_out", (b + 1) * 8'h11, d);
            end
        end
        do_request(1'b1, 1'b0, 32'h0000_0028, '0, h, d);
        if (d !== 32'h4433_2211) report_mismatch("data_out", 32'h4433_2211, d);
        finish_test("byte merge", start);
    endtask

    task automatic test_lru();
        int    start;
        int    seq_tags [11] = '{3, 4, 5, 6, 3, 7, 3, 6, 4, 7, 5};
        logic  seq_hits [11] = '{0, 0, 0, 0, 1, 0, 1, 1, 0, 1, 0};
        logic  h;
        word_t d;
        start = errors;
        // First four fill the cache, whatever was resident before
        for (int i = 0; i < 11; i++) begin
            do_request(1'b1, 1'b0, addr_t'(seq_tags[i] * 16 + 4), '0, h, d);
            if (i >= 4 && h !== seq_hits[i]) begin
                report_mismatch("hit", seq_hits[i], h);
            end
        end
        finish_test("lru replacement", start);
    endtask

    task automatic test_writeback();
        int    start;
        logic  h;
        word_t d;
        start = errors;
        do_request(1'b0, 1'b0, 32'h0000_0008, 32'hcafe_f00d, h, d);
        // Four other lines push tag 0 out through a write-back
        for (int t = 1; t <= 4; t++) begin
            do_request(1'b1, 1'b0, addr_t'(t * 16), '0, h, d);
        end
        do_request(1'b1, 1'b0, 32'h0000_0008, '0, h, d);
        if (h) report_failure("tag 0 was still resident after four other lines");
        if (d !== 32'hcafe_f00d) report_mismatch("data_out", 32'hcafe_f00d, d);
        finish_test("dirty write-back", start);
    endtask

    task automatic test_random();
        int          start;
        logic [2:0]  tag;
        logic [3:0]  offset;
        logic        rd;
        logic        bytes;
        word_t       wdata;
        logic        h;
        word_t       d;
        start = errors;
        for (int n = 0; n < 600; n++) begin
            tag    = random_bits(3);
            offset = random_bits(4);
            rd     = random_bits(1);
            bytes  = random_bits(1);
            wdata  = random_bits(32);
            do_request(rd, bytes, addr_t'({tag, offset}), wdata, h, d);
        end
        finish_test("random mixed traffic", start);
    endtask

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        lfsr_state   = 32'h4e21;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset        = 1'b1;
        access       = 1'b0;
        op           = 1'b0;
        byte_op      = 1'b0;
        address      = '0;
        data_in      = '0;
        model_reset();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        test_reset();
        test_word();
        test_bytes();
        test_lru();
        test_writeback();
        test_random();
        repeat (2) @(posedge clk);
        $display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, u_dut.u_properties.failures);
        if (errors == 0 && tests_failed == 0 && u_dut.u_properties.failures == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+design
design/cache_pkg.sv
design/mem_line_if.sv
design/tag_match.sv
design/lru_tracker.sv
design/cache_controller.sv
design/line_memory.sv
design/cache_top.sv
bench/cache_properties.sv
bench/cache_tb.sv
